// ==== design/mem_sys_pkg.sv ====
package mem_sys_pkg;

   //////////////////////////////////////////////////////////////////////
   // Address fields
   //////////////////////////////////////////////////////////////////////

   // Tag in bits 15..11, index in bits 10..3, word select in bits 2..1
   localparam int tag_w          = 5;
   localparam int index_w        = 8;
   localparam int word_sel_w     = 2;
   localparam int addr_w         = 16;

   // Line geometry
   localparam int words_per_line = 4;
   localparam int data_w         = 16;

   //////////////////////////////////////////////////////////////////////
   // Main memory
   //////////////////////////////////////////////////////////////////////

   localparam int mem_words        = 32768;
   localparam int mem_read_lat     = 2;
   localparam int bank_busy_cycles = 4;

   // Miss handling steps
   typedef enum logic [2:0] {
      st_idle,
      st_write_back,
      st_fill_req,
      st_fill_drain,
      st_retry,
      st_done,
      st_err
   } ctrl_state_e;

endpackage

// ==== design/cache_way_if.sv ====
`timescale 1ns/1ns

interface cache_way_if
   import mem_sys_pkg::*;
();

   // Controller side
   logic                  en;
   logic                  comp;
   logic                  write;
   logic [tag_w-1:0]      tag_in;
   logic [index_w-1:0]    index;
   logic [word_sel_w-1:0] word_sel;
   logic [data_w-1:0]     data_in;
   logic                  set_dirty;

   // Way side
   logic                  hit;
   logic                  valid;
   logic                  dirty;
   logic [tag_w-1:0]      tag_out;
   logic [data_w-1:0]     data_out;

   modport ctrl (
      output en, comp, write, tag_in, index, word_sel, data_in, set_dirty,
      input  hit, valid, dirty, tag_out, data_out
   );

   modport way (
      input  en, comp, write, tag_in, index, word_sel, data_in, set_dirty,
      output hit, valid, dirty, tag_out, data_out
   );

endinterface

// ==== design/bank_mem_if.sv ====
`timescale 1ns/1ns

interface bank_mem_if
   import mem_sys_pkg::*;
();

   // Request from the controller
   logic              rd;
   logic              wr;
   logic [addr_w-1:0] addr;
   logic [data_w-1:0] data_in;

   // Response and back-pressure
   logic [data_w-1:0] data_out;
   logic              data_valid;
   logic              stall;

   modport ctrl (
      output rd, wr, addr, data_in,
      input  data_out, data_valid, stall
   );

   modport mem (
      input  rd, wr, addr, data_in,
      output data_out, data_valid, stall
   );

endinterface

// ==== design/cache_way.sv ====
`timescale 1ns/1ns

module cache_way
   import mem_sys_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   cache_way_if.way  bus
);

   //////////////////////////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////////////////////////

   logic [2**index_w-1:0] valid_q;
   logic [2**index_w-1:0] dirty_q;
   logic [tag_w-1:0]      tag_q  [2**index_w];
   logic [data_w-1:0]     data_q [2**index_w][words_per_line];

   logic tag_match;
   logic hit_write;
   logic fill_write;

   // Combinational lookup
   assign tag_match    = valid_q[bus.index] && (tag_q[bus.index] == bus.tag_in);
   assign bus.hit      = bus.en && bus.comp && tag_match;
   assign bus.valid    = valid_q[bus.index];
   assign bus.dirty    = dirty_q[bus.index];
   assign bus.tag_out  = tag_q[bus.index];
   assign bus.data_out = data_q[bus.index][bus.word_sel];

   // Compare write only lands on a hit
   assign hit_write  = bus.write && bus.hit;
   // Line write installs the tag
   assign fill_write = bus.en && !bus.comp && bus.write;

   //////////////////////////////////////////////////////////////////////
   // Line state
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (fill_write) begin
         valid_q[bus.index] <= 1'b1;
         dirty_q[bus.index] <= bus.set_dirty;
      end else if (hit_write) begin
         dirty_q[bus.index] <= 1'b1;
      end
   end

   // Tag and data arrays
   always_ff @(posedge clk) begin
      if (fill_write) begin
         tag_q[bus.index] <= bus.tag_in;
      end
      if (fill_write || hit_write) begin
         data_q[bus.index][bus.word_sel] <= bus.data_in;
      end
   end

   // Controller must always drive a defined enable
   a_en_known: assert property (
      @(posedge clk) disable iff (!rst_n)
      !$isunknown(bus.en)
   );

endmodule

// ==== design/four_bank_mem.sv ====
`timescale 1ns/1ns

module four_bank_mem
   import mem_sys_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   bank_mem_if.mem  bus
);

   typedef logic [$clog2(bank_busy_cycles+1)-1:0] busy_t;

   logic [data_w-1:0]            bank_q [words_per_line][mem_words/words_per_line];
   busy_t                        busy_q [words_per_line];
   logic [data_w-1:0]            rd_data_q [mem_read_lat];
   logic [mem_read_lat-1:0]      rd_valid_q;
   logic [word_sel_w-1:0]        bank;
   logic [addr_w-word_sel_w-2:0] row;
   logic                         req;

   // Word address bits 2..1 pick the bank
   assign bank = bus.addr[1 +: word_sel_w];
   assign row  = bus.addr[addr_w-1:word_sel_w+1];
   assign req  = bus.rd || bus.wr;

   assign bus.stall      = (busy_q[bank] != '0);
   assign bus.data_out   = rd_data_q[mem_read_lat-1];
   assign bus.data_valid = rd_valid_q[mem_read_lat-1];

   // Memory starts out all zero
   initial begin
      for (int b = 0; b < words_per_line; b++) begin
         for (int r = 0; r < mem_words/words_per_line; r++) begin
            bank_q[b][r] = '0;
         end
      end
   end

   always @(posedge clk) begin
      if (bus.wr) begin
         bank_q[bank][row] <= bus.data_in;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Bank timers and read pipeline
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q     <= '{default: '0};
         rd_valid_q <= '0;
      end else begin
         for (int b = 0; b < words_per_line; b++) begin
            if (req && bank == b) begin
               busy_q[b] <= busy_t'(bank_busy_cycles);
            end else if (busy_q[b] != '0) begin
               busy_q[b] <= busy_q[b] - busy_t'(1);
            end
         end
         rd_valid_q <= {rd_valid_q[mem_read_lat-2:0], bus.rd};
      end
   end

   always_ff @(posedge clk) begin
      rd_data_q[0] <= bank_q[bank][row];
      for (int s = 1; s < mem_read_lat; s++) begin
         rd_data_q[s] <= rd_data_q[s-1];
      end
   end

   // Requester has to honour the busy timer of the addressed bank
   a_no_busy_req: assert property (
      @(posedge clk) disable iff (!rst_n)
      req |-> !bus.stall
   );

endmodule

// ==== design/cache_ctrl.sv ====
`timescale 1ns/1ns

module cache_ctrl
   import mem_sys_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic [addr_w-1:0] addr,
   input  logic [data_w-1:0] data_in,
   input  logic              rd,
   input  logic              wr,
   output logic [data_w-1:0] data_out,
   output logic              done,
   output logic              stall,
   output logic              cache_hit,
   output logic              err,
   cache_way_if.ctrl         way0,
   cache_way_if.ctrl         way1,
   bank_mem_if.ctrl          mem
);

   ctrl_state_e           state_q;
   ctrl_state_e           state_d;
   logic [word_sel_w-1:0] issue_cnt_q;
   logic [word_sel_w-1:0] ret_cnt_q;
   logic                  victim_q;
   logic                  victim_ff_q;

   logic [tag_w-1:0]      req_tag;
   logic [index_w-1:0]    req_index;
   logic [word_sel_w-1:0] req_word;
   logic                  bad_req;
   logic                  req_ok;
   logic                  any_hit;
   logic                  miss;
   logic                  pick_way;
   logic                  pick_dirty;
   logic [tag_w-1:0]      victim_tag;
   logic [data_w-1:0]     victim_data;
   logic                  access_phase;
   logic                  fill_phase;
   logic                  issue_ok;
   logic                  ret_ok;
   logic                  access_en;
   logic                  line_en;
   logic                  way_write;
   logic [word_sel_w-1:0] way_word;
   logic [data_w-1:0]     way_data;

   assign req_tag   = addr[addr_w-1 -: tag_w];
   assign req_index = addr[word_sel_w+1 +: index_w];
   assign req_word  = addr[1 +: word_sel_w];

   // Odd address or both strobes is never served
   assign bad_req = (rd && wr) || ((rd || wr) && addr[0]);
   assign req_ok  = (rd ^ wr) && !addr[0];

   assign any_hit = way0.hit || way1.hit;
   assign miss    = (state_q == st_idle) && req_ok && !any_hit;

   //////////////////////////////////////////////////////////////////////
   // Victim selection
   //////////////////////////////////////////////////////////////////////

   // Empty way wins over the round-robin flop
   always_comb begin
      if (!way0.valid) begin
         pick_way = 1'b0;
      end else if (!way1.valid) begin
         pick_way = 1'b1;
      end else begin
         pick_way = victim_ff_q;
      end
   end

   assign pick_dirty  = pick_way ? (way1.valid && way1.dirty) : (way0.valid && way0.dirty);
   assign victim_tag  = victim_q ? way1.tag_out : way0.tag_out;
   assign victim_data = victim_q ? way1.data_out : way0.data_out;

   //////////////////////////////////////////////////////////////////////
   // Memory side
   //////////////////////////////////////////////////////////////////////

   assign access_phase = state_q inside {st_idle, st_retry, st_done};
   assign fill_phase   = state_q inside {st_fill_req, st_fill_drain};

   // Issue only into a free bank
   assign issue_ok = (state_q inside {st_write_back, st_fill_req}) && !mem.stall;
   assign ret_ok   = fill_phase && mem.data_valid;

   // Write-back goes to the victim's old line address
   assign mem.addr = {(state_q == st_write_back) ? victim_tag : req_tag,
                      req_index, issue_cnt_q, 1'b0};
   assign mem.wr      = issue_ok && (state_q == st_write_back);
   assign mem.rd      = issue_ok && (state_q == st_fill_req);
   assign mem.data_in = victim_data;

   //////////////////////////////////////////////////////////////////////
   // Way side
   //////////////////////////////////////////////////////////////////////

   assign access_en = (state_q == st_idle) ? req_ok : (state_q inside {st_retry, st_done});
   assign line_en   = (state_q == st_write_back) || ret_ok;
   assign way_write = fill_phase || (wr && (state_q inside {st_idle, st_retry}));
   assign way_data  = fill_phase ? mem.data_out : data_in;

   always_comb begin
      if (access_phase) begin
         way_word = req_word;
      end else if (fill_phase) begin
         way_word = ret_cnt_q;
      end else begin
         way_word = issue_cnt_q;
      end
   end

   assign way0.en        = access_en || (line_en && !victim_q);
   assign way1.en        = access_en || (line_en && victim_q);
   assign way0.comp      = access_phase;
   assign way1.comp      = access_phase;
   assign way0.write     = way_write;
   assign way1.write     = way_write;
   assign way0.tag_in    = req_tag;
   assign way1.tag_in    = req_tag;
   assign way0.index     = req_index;
   assign way1.index     = req_index;
   assign way0.word_sel  = way_word;
   assign way1.word_sel  = way_word;
   assign way0.data_in   = way_data;
   assign way1.data_in   = way_data;
   // Fresh lines come in clean and the retry marks a write
   assign way0.set_dirty = 1'b0;
   assign way1.set_dirty = 1'b0;

   // Requester outputs
   assign cache_hit = (state_q == st_idle) && req_ok && any_hit;
   assign done      = cache_hit || (state_q == st_done);
   assign stall     = !(state_q inside {st_idle, st_err});
   assign err       = bad_req || (state_q == st_err);
   assign data_out  = way1.hit ? way1.data_out : way0.data_out;

   //////////////////////////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle: begin
            if (bad_req) begin
               state_d = st_err;
            end else if (miss) begin
               state_d = pick_dirty ? st_write_back : st_fill_req;
            end
         end
         st_write_back: begin
            if (issue_ok && issue_cnt_q == '1) begin
               state_d = st_fill_req;
            end
         end
         st_fill_req: begin
            if (issue_ok && issue_cnt_q == '1) begin
               state_d = st_fill_drain;
            end
         end
         st_fill_drain: begin
            if (ret_ok && ret_cnt_q == '1) begin
               state_d = st_retry;
            end
         end
         st_retry: state_d = st_done;
         st_done:  state_d = st_idle;
         default:  state_d = st_err;
      endcase
   end

   // Counters wrap back to zero after each line
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q     <= st_idle;
         issue_cnt_q <= '0;
         ret_cnt_q   <= '0;
         victim_q    <= 1'b0;
         victim_ff_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (issue_ok) begin
            issue_cnt_q <= issue_cnt_q + 1'b1;
         end
         if (ret_ok) begin
            ret_cnt_q <= ret_cnt_q + 1'b1;
         end
         if (miss) begin
            victim_q <= pick_way;
         end
         if (cache_hit) begin
            victim_ff_q <= !victim_ff_q;
         end
      end
   end

   a_mem_one_op: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(mem.rd && mem.wr)
   );

   a_done_not_err: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(done && err)
   );

endmodule

// ==== design/mem_system.sv ====
`timescale 1ns/1ns

module mem_system
   import mem_sys_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic [addr_w-1:0] addr,
   input  logic [data_w-1:0] data_in,
   input  logic              rd,
   input  logic              wr,
   output logic [data_w-1:0] data_out,
   output logic              done,
   output logic              stall,
   output logic              cache_hit,
   output logic              err
);

   cache_way_if way0_bus ();
   cache_way_if way1_bus ();
   bank_mem_if  mem_bus ();

   // Two ways of the set-associative array
   cache_way way0_i (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (way0_bus.way)
   );

   cache_way way1_i (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (way1_bus.way)
   );

   cache_ctrl ctrl_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err),
      .way0      (way0_bus.ctrl),
      .way1      (way1_bus.ctrl),
      .mem       (mem_bus.ctrl)
   );

   // Backing store
   four_bank_mem mem_i (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (mem_bus.mem)
   );

endmodule

// ==== test/mem_system_tb.sv ====
`timescale 1ns/1ns

module mem_system_tb
   import mem_sys_pkg::*;
();

   typedef struct packed {
      logic              is_wr;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
      logic              exp_hit;
      logic              chk_hit;
   } req_t;

   localparam int n_rand = 48;

   logic              clk;
   logic              rst_n;
   logic [addr_w-1:0] addr;
   logic [data_w-1:0] data_in;
   logic              rd;
   logic              wr;
   logic [data_w-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;
   logic              err;

   req_t              req_tbl[$];
   logic [data_w-1:0] ref_mem [mem_words];
   logic [31:0]       rng;
   logic              tbl_ready;

   mem_system dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("Test failures found");
         $fatal(1);
      end
   endtask

   // Every entry draws write data from the generator
   task automatic add_req(input logic is_wr, input logic [addr_w-1:0] a,
                          input logic exp_hit, input logic chk_hit);
      req_t r;
      rng       = xorshift32(rng);
      r.is_wr   = is_wr;
      r.addr    = a;
      r.data    = rng[data_w-1:0];
      r.exp_hit = exp_hit;
      r.chk_hit = chk_hit;
      req_tbl.push_back(r);
   endtask

   task automatic build_table();
      // First touch misses and repeats hit
      add_req(1'b0, 16'h0000, 1'b0, 1'b1);
      add_req(1'b0, 16'h0000, 1'b1, 1'b1);
      add_req(1'b1, 16'h0000, 1'b1, 1'b1);
      add_req(1'b1, 16'h0000, 1'b1, 1'b1);
      add_req(1'b0, 16'h0000, 1'b1, 1'b1);
      // Write one word and read back the whole line
      add_req(1'b1, 16'h1894, 1'b0, 1'b1);
      add_req(1'b0, 16'h1890, 1'b1, 1'b1);
      add_req(1'b0, 16'h1892, 1'b1, 1'b1);
      add_req(1'b0, 16'h1894, 1'b1, 1'b1);
      add_req(1'b0, 16'h1896, 1'b1, 1'b1);
      // Three tags fighting over index 0x40
      add_req(1'b1, 16'h0a02, 1'b0, 1'b1);
      add_req(1'b1, 16'h1202, 1'b0, 1'b1);
      add_req(1'b1, 16'h1a02, 1'b0, 1'b1);
      add_req(1'b0, 16'h0a02, 1'b0, 1'b0);
      add_req(1'b0, 16'h1202, 1'b0, 1'b0);
      add_req(1'b0, 16'h1a02, 1'b0, 1'b0);
      // Random tags over four sets for frequent evictions
      for (int i = 0; i < n_rand; i++) begin
         rng = xorshift32(rng);
         add_req(rng[0], {rng[20:16], 6'b0, rng[9:8], rng[2:1], 1'b0}, 1'b0, 1'b0);
      end
   endtask

   task automatic apply_reset();
      rst_n <= 1'b0;
      rd    <= 1'b0;
      wr    <= 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
   endtask

   // Drive one request and hold it until done
   task automatic run_req(input req_t r);
      int waited;
      waited = 0;
      @(posedge clk);
      addr    <= r.addr;
      data_in <= r.data;
      rd      <= !r.is_wr;
      wr      <= r.is_wr;
      @(negedge clk);
      check_value("stall", stall, 0);
      check_value("err", err, 0);
      while (!done) begin
         waited++;
         @(negedge clk);
         check_value("stall", stall, 1);
      end
      if (r.chk_hit) begin
         check_value("cache_hit", cache_hit, r.exp_hit);
         if (r.exp_hit) begin
            check_value("done delay", waited, 0);
         end
      end
      if (waited > 0) begin
         check_value("cache_hit", cache_hit, 0);
      end
      check_value("err", err, 0);
      if (r.is_wr) begin
         ref_mem[r.addr[addr_w-1:1]] = r.data;
      end else begin
         check_value("data_out", data_out, ref_mem[r.addr[addr_w-1:1]]);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      rst_n     = 1'b0;
      addr      = '0;
      data_in   = '0;
      rd        = 1'b0;
      wr        = 1'b0;
      tbl_ready = 1'b0;
      rng       = 32'h016a_2fdf;
      for (int i = 0; i < mem_words; i++) begin
         ref_mem[i] = '0;
      end
      build_table();
      tbl_ready = 1'b1;

      apply_reset();
      @(negedge clk);
      check_value("done", done, 0);
      check_value("stall", stall, 0);
      check_value("err", err, 0);

      foreach (req_tbl[i]) begin
         run_req(req_tbl[i]);
      end

      // Odd address
      @(posedge clk);
      addr <= 16'h0101;
      rd   <= 1'b1;
      wr   <= 1'b0;
      @(negedge clk);
      check_value("err", err, 1);
      check_value("done", done, 0);

      @(posedge clk);
      apply_reset();
      @(negedge clk);
      check_value("err", err, 0);

      // Both strobes at once and err must stick afterwards
      @(posedge clk);
      addr <= 16'h0004;
      rd   <= 1'b1;
      wr   <= 1'b1;
      @(negedge clk);
      check_value("err", err, 1);
      check_value("done", done, 0);
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;
      @(negedge clk);
      check_value("err", err, 1);

      $display("All tests passed!");
      $finish;
   end

   // Watchdog sized from the request table
   initial begin
      int limit;
      wait (tbl_ready);
      limit = (req_tbl.size() + 2) * 40;
      repeat (limit) @(posedge clk);
      $display("Timeout: the request sequence did not finish within %0d cycles", limit);
      $display("Test failures found");
      $fatal(1);
   end

endmodule

// ==== verilog.f ====
design/mem_sys_pkg.sv
design/cache_way_if.sv
design/bank_mem_if.sv
design/cache_way.sv
design/four_bank_mem.sv
design/cache_ctrl.sv
design/mem_system.sv
test/mem_system_tb.sv

// ==== Bender.yml ====
package:
  name: mem_system

sources:
  - design/mem_sys_pkg.sv
  - design/cache_way_if.sv
  - design/bank_mem_if.sv
  - design/cache_way.sv
  - design/four_bank_mem.sv
  - design/cache_ctrl.sv
  - design/mem_system.sv
  - target: test
    files:
      - test/mem_system_tb.sv
